//--- verilog/bitparse_cfg_pkg.sv
package bitparse_cfg_pkg;

  // one codec word as read from the source
  localparam int WORD_W = 128;

  // funnel holds a partial word plus one fresh word
  localparam int SHIFTER_W = 255;

  // fullness count and per-block consume length
  localparam int FULL_W = 8;

  // mpp step size field
  localparam int STEP_W = 3;

  // bits per bpv, fls always on
  localparam int BPV_BITS = 5;

  localparam int NUM_SUB = 4;

endpackage

//--- verilog/bitparse_mode_pkg.sv
package bitparse_mode_pkg;

  typedef enum logic [2:0] {
    XFM    = 3'd0,
    BP     = 3'd1,
    MPP    = 3'd2,
    MPPF   = 3'd3,
    BPSKIP = 3'd4
  } blk_mode_e;

  // mode plus bits used by mode and flatness headers
  typedef struct packed {
    blk_mode_e                           mode;
    logic [bitparse_cfg_pkg::FULL_W-1:0] hdr_bits;
  } mode_hdr_t;

  // header field lengths
  localparam logic [bitparse_cfg_pkg::FULL_W-1:0] SAME_BITS       = 8'd1;
  localparam logic [bitparse_cfg_pkg::FULL_W-1:0] MODE_SHORT_BITS = 8'd3;
  localparam logic [bitparse_cfg_pkg::FULL_W-1:0] MODE_LONG_BITS  = 8'd4;
  localparam logic [bitparse_cfg_pkg::FULL_W-1:0] FLAT_OFF_BITS   = 8'd1;
  localparam logic [bitparse_cfg_pkg::FULL_W-1:0] FLAT_ON_BITS    = 8'd3;
  localparam logic [bitparse_cfg_pkg::FULL_W-1:0] CSC_BITS        = 8'd1;

endpackage

//--- verilog/bit_window_if.sv
interface bit_window_if;
  import bitparse_cfg_pkg::*;

  // top WORD_W bits of the funnel shifter
  logic [WORD_W-1:0] window;
  logic              window_vld;
  // bits retired at the next edge
  logic [FULL_W-1:0] consume;
  logic              refill;

  modport shifter (input consume, refill, output window, window_vld);

  modport counter (input consume, refill);

  modport ctrl (input consume, output refill);

  modport dec (input window, window_vld, output consume);

endinterface

//--- verilog/parse_ctrl_fsm.sv
module parse_ctrl_fsm (
  input  logic                                clk,
  input  logic                                rstn,
  input  logic                                start_dec,
  input  logic [bitparse_cfg_pkg::FULL_W-1:0] fullness,
  bit_window_if.ctrl                          win,
  output logic                                parsing
);
  import bitparse_cfg_pkg::*;

  typedef enum logic [1:0] {IDLE, FILL, PARSE} state_e;

  state_e            state;
  state_e            state_nxt;
  logic [FULL_W-1:0] after;

  // bits left once this cycle's block is retired
  assign after = fullness - win.consume;
  assign win.refill = start_dec && (after < FULL_W'(WORD_W));

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:    if (win.refill) state_nxt = FILL;
      FILL:    state_nxt = PARSE;
      // drained after start_dec dropped
      PARSE:   if (!start_dec && fullness == '0) state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      state <= IDLE;
    else
      state <= state_nxt;
  end

  // first word already sits in the window during FILL
  assign parsing = (state != IDLE);

endmodule

//--- verilog/fullness_cnt.sv
module fullness_cnt (
  input  logic                                clk,
  input  logic                                rstn,
  bit_window_if.counter                       win,
  output logic [bitparse_cfg_pkg::FULL_W-1:0] fullness
);
  import bitparse_cfg_pkg::*;

  logic [FULL_W-1:0] cnt;
  logic [FULL_W-1:0] after;

  // consume is already zero without a valid window
  assign after = cnt - win.consume;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      cnt <= '0;
    end
    else if (win.refill)
    begin
      // after stays below WORD_W here, so no overflow
      cnt <= after + FULL_W'(WORD_W);
    end
    else
    begin
      cnt <= after;
    end
  end

  assign fullness = cnt;

endmodule

//--- verilog/funnel_shifter.sv
module funnel_shifter (
  input  logic                                clk,
  input  logic                                rstn,
  input  logic                                parsing,
  input  logic [bitparse_cfg_pkg::FULL_W-1:0] fullness,
  input  logic [bitparse_cfg_pkg::WORD_W-1:0] codec_data,
  bit_window_if.shifter                       win
);
  import bitparse_cfg_pkg::*;

  logic [SHIFTER_W-1:0] shifter;
  logic [SHIFTER_W-1:0] shifted;
  logic [SHIFTER_W-1:0] placed;
  logic [FULL_W-1:0]    after;

  // valid bits are left aligned, zeros below them
  assign shifted = shifter << win.consume;
  assign after = fullness - win.consume;

  // new word lands right behind the remaining bits
  // an empty shifter gives after of zero, i.e. the top
  assign placed = {codec_data, {(SHIFTER_W - WORD_W){1'b0}}} >> after;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      // or merge below needs a zero tail
      shifter <= '0;
    end
    else if (win.refill)
    begin
      shifter <= shifted | placed;
    end
    else
    begin
      shifter <= shifted;
    end
  end

  assign win.window = shifter[SHIFTER_W-1 -: WORD_W];
  assign win.window_vld = parsing && (fullness != '0);

endmodule

//--- verilog/mode_header_dec.sv
module mode_header_dec (
  input  logic                                clk,
  input  logic                                rstn,
  input  logic [bitparse_cfg_pkg::WORD_W-1:0] window,
  input  logic                                window_vld,
  output bitparse_mode_pkg::mode_hdr_t        hdr
);
  import bitparse_cfg_pkg::*;
  import bitparse_mode_pkg::*;

  blk_mode_e         prev_mode;
  blk_mode_e         mode;
  logic              same_flag;
  logic              long_mode;
  logic              flat_flag;
  logic [FULL_W-1:0] mode_bits;

  assign same_flag = window[WORD_W-1];
  // 11 escapes to mppf / bpskip
  assign long_mode = !same_flag && (window[WORD_W-2 -: 2] == 2'b11);

  always_comb
  begin
    if (same_flag)
    begin
      mode      = prev_mode;
      mode_bits = SAME_BITS;
    end
    else if (long_mode)
    begin
      mode      = window[WORD_W-4] ? MPPF : BPSKIP;
      mode_bits = MODE_LONG_BITS;
    end
    else
    begin
      mode      = blk_mode_e'({1'b0, window[WORD_W-2 -: 2]});
      mode_bits = MODE_SHORT_BITS;
    end
  end

  // flatness flag follows the mode field, type bits are skipped
  always_comb
  begin
    if (same_flag)
      flat_flag = window[WORD_W-2];
    else if (long_mode)
      flat_flag = window[WORD_W-5];
    else
      flat_flag = window[WORD_W-4];
  end

  always_comb
  begin
    hdr.mode     = mode;
    hdr.hdr_bits = mode_bits + (flat_flag ? FLAT_ON_BITS : FLAT_OFF_BITS);
  end

  // full 3-bit mode kept so repeats of mppf and bpskip work
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      prev_mode <= XFM;
    else if (window_vld)
      prev_mode <= mode;
  end

endmodule

//--- verilog/block_payload_dec.sv
module block_payload_dec (
  input  logic [bitparse_cfg_pkg::WORD_W-1:0]  window,
  input  bitparse_mode_pkg::mode_hdr_t         hdr,
  bit_window_if.dec                            win,
  output logic                                 blk_vld,
  output logic                                 mode_xfm,
  output logic                                 mode_bp,
  output logic                                 mode_mpp,
  output logic                                 mode_mppf,
  output logic                                 mode_bpskip,
  output logic [bitparse_cfg_pkg::NUM_SUB-1:0] use2x2,
  output logic [bitparse_cfg_pkg::STEP_W-1:0]  mpp_step_size
);
  import bitparse_cfg_pkg::*;
  import bitparse_mode_pkg::*;

  logic              vld;
  logic [WORD_W-1:0] aligned;
  logic [NUM_SUB-1:0] flags;
  logic [STEP_W-1:0] step;
  logic [FULL_W-1:0] blk_len;

  assign vld = win.window_vld;

  // payload starts at the msb once the header is gone
  assign aligned = window << hdr.hdr_bits;
  // colour space bit skipped
  assign step = aligned[WORD_W-2 -: STEP_W];

  always_comb
  begin
    for (int i = 0; i < NUM_SUB; i++)
      flags[i] = aligned[WORD_W-1-i];
  end

  // use2x2[0] picks one 2x2 bpv or two 2x1 bpvs
  always_comb
  begin
    case (hdr.mode)
      MPP:     blk_len = hdr.hdr_bits + CSC_BITS + FULL_W'(STEP_W);
      BP:      blk_len = hdr.hdr_bits + FULL_W'(NUM_SUB)
                         + (flags[0] ? FULL_W'(BPV_BITS) : FULL_W'(2 * BPV_BITS));
      default: blk_len = hdr.hdr_bits;
    endcase
  end

  assign blk_vld     = vld;
  assign mode_xfm    = vld && (hdr.mode == XFM);
  assign mode_bp     = vld && (hdr.mode == BP);
  assign mode_mpp    = vld && (hdr.mode == MPP);
  assign mode_mppf   = vld && (hdr.mode == MPPF);
  assign mode_bpskip = vld && (hdr.mode == BPSKIP);

  assign use2x2        = mode_bp ? flags : '0;
  assign mpp_step_size = mode_mpp ? step : '0;
  assign win.consume   = vld ? blk_len : '0;

endmodule

//--- verilog/bitparse_top.sv
module bitparse_top (
  input  logic                                 clk,
  input  logic                                 rstn,
  input  logic                                 start_dec,
  input  logic [bitparse_cfg_pkg::WORD_W-1:0]  codec_data,
  output logic                                 codec_data_rd_en,
  output logic                                 blk_vld,
  output logic                                 mode_xfm,
  output logic                                 mode_bp,
  output logic                                 mode_mpp,
  output logic                                 mode_mppf,
  output logic                                 mode_bpskip,
  output logic [bitparse_cfg_pkg::NUM_SUB-1:0] use2x2,
  output logic [bitparse_cfg_pkg::STEP_W-1:0]  mpp_step_size
);
  import bitparse_cfg_pkg::*;
  import bitparse_mode_pkg::*;

  logic [FULL_W-1:0] fullness;
  logic              parsing;
  mode_hdr_t         hdr;

  bit_window_if win_if ();

  parse_ctrl_fsm u_ctrl (
    .clk       (clk),
    .rstn      (rstn),
    .start_dec (start_dec),
    .fullness  (fullness),
    .win       (win_if),
    .parsing   (parsing)
  );

  fullness_cnt u_fullness (.clk(clk), .rstn(rstn), .win(win_if), .fullness(fullness));

  funnel_shifter u_shifter (
    .clk        (clk),
    .rstn       (rstn),
    .parsing    (parsing),
    .fullness   (fullness),
    .codec_data (codec_data),
    .win        (win_if)
  );

  mode_header_dec u_mode_dec (
    .clk        (clk),
    .rstn       (rstn),
    .window     (win_if.window),
    .window_vld (win_if.window_vld),
    .hdr        (hdr)
  );

  block_payload_dec u_payload_dec (
    .window        (win_if.window),
    .hdr           (hdr),
    .win           (win_if),
    .blk_vld       (blk_vld),
    .mode_xfm      (mode_xfm),
    .mode_bp       (mode_bp),
    .mode_mpp      (mode_mpp),
    .mode_mppf     (mode_mppf),
    .mode_bpskip   (mode_bpskip),
    .use2x2        (use2x2),
    .mpp_step_size (mpp_step_size)
  );

  assign codec_data_rd_en = win_if.refill;

endmodule

//--- test/bitparse_chk.sv
module bitparse_chk (
  input logic clk,
  input logic rstn,
  input logic start_dec,
  input logic codec_data_rd_en,
  input logic blk_vld
);

  // a fresh word always leaves a block in the window
  refill_then_block: assert property (@(posedge clk) disable iff (!rstn)
    codec_data_rd_en |=> blk_vld)
    else $error("no valid block in the cycle after a read");

  // one block per cycle while decoding is enabled
  back_to_back: assert property (@(posedge clk) disable iff (!rstn)
    (blk_vld && start_dec) |=> blk_vld)
    else $error("block stream stalled with start_dec high");

  first_block_after_read: assert property (@(posedge clk) disable iff (!rstn)
    $rose(blk_vld) |-> $past(codec_data_rd_en))
    else $error("block valid rose without a read in the cycle before");

endmodule

bind bitparse_top bitparse_chk u_chk (
  .clk              (clk),
  .rstn             (rstn),
  .start_dec        (start_dec),
  .codec_data_rd_en (codec_data_rd_en),
  .blk_vld          (blk_vld)
);

//--- test/tb_clk_gen.sv
module tb_clk_gen (
  output logic clk,
  output logic rstn
);
  localparam int PERIOD = 100;
  localparam int RST_CYC = 16;

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // release a little after the edge, like all other inputs
  initial
  begin
    rstn = 1'b0;
    repeat (RST_CYC) @(posedge clk);
    #5;
    rstn = 1'b1;
  end

endmodule

//--- test/bitparse_tb.sv
module bitparse_tb;
  import bitparse_cfg_pkg::*;
  import bitparse_mode_pkg::*;

  localparam int NUM_BLK = 200;
  localparam int MAX_WORDS = 64;
  localparam int RST_CYC = 16;
  // reset, one block per cycle, margin for start and fill
  localparam int TIMEOUT_CYC = RST_CYC + NUM_BLK + 84;

  typedef struct packed {
    blk_mode_e          mode;
    logic [NUM_SUB-1:0] use2x2;
    logic [STEP_W-1:0]  step;
    int                 len;
  } exp_blk_t;

  logic               clk;
  logic               rstn;
  logic               start_dec;
  logic [WORD_W-1:0]  codec_data;
  logic               codec_data_rd_en;
  logic               blk_vld;
  logic               mode_xfm;
  logic               mode_bp;
  logic               mode_mpp;
  logic               mode_mppf;
  logic               mode_bpskip;
  logic [NUM_SUB-1:0] use2x2;
  logic [STEP_W-1:0]  mpp_step_size;

  // bitstream, msb of word 0 first
  logic               stream [MAX_WORDS*WORD_W];
  logic [WORD_W-1:0]  words [MAX_WORDS];
  int                 nbits;
  int                 word_idx;
  logic               took_word;
  int                 model_full;
  logic               started;
  int                 pos;
  blk_mode_e          prev;
  int                 blk_cnt;
  int                 err_cnt;
  int                 cycle_cnt;

  tb_clk_gen u_clk_gen (
    .clk  (clk),
    .rstn (rstn)
  );

  bitparse_top i_bitparse_top (
    .clk              (clk),
    .rstn             (rstn),
    .start_dec        (start_dec),
    .codec_data       (codec_data),
    .codec_data_rd_en (codec_data_rd_en),
    .blk_vld          (blk_vld),
    .mode_xfm         (mode_xfm),
    .mode_bp          (mode_bp),
    .mode_mpp         (mode_mpp),
    .mode_mppf        (mode_mppf),
    .mode_bpskip      (mode_bpskip),
    .use2x2           (use2x2),
    .mpp_step_size    (mpp_step_size)
  );

  task automatic put_bits(input int unsigned val, input int n);
    for (int i = n - 1; i >= 0; i--)
    begin
      stream[nbits] = val[i];
      nbits++;
    end
  endtask

  task automatic build_stream();
    int unsigned m;
    int unsigned u;
    int unsigned last;
    last = 0;
    nbits = 0;
    for (int i = 0; i < MAX_WORDS * WORD_W; i++)
      stream[i] = 1'b0;
    for (int b = 0; b < NUM_BLK; b++)
    begin
      m = $urandom % 5;
      // about a third of the blocks repeat the previous mode
      if ($urandom % 3 == 0)
      begin
        put_bits(1, 1);
        m = last;
      end
      else if (m >= 3)
        put_bits(m == 3 ? 7 : 6, 4);
      else
        put_bits(m, 3);
      if ($urandom % 2 == 1)
        put_bits(4 + $urandom % 4, 3);
      else
        put_bits(0, 1);
      if (m == 2)
        put_bits($urandom % 16, 4);
      if (m == 1)
      begin
        u = $urandom % 16;
        put_bits(u, 4);
        put_bits($urandom, u[3] ? 5 : 10);
      end
      last = m;
    end
    for (int w = 0; w < MAX_WORDS; w++)
      for (int k = 0; k < WORD_W; k++)
        words[w][WORD_W-1-k] = stream[w*WORD_W + k];
  endtask

  // expected outputs and length of the block starting at bit p0
  function automatic exp_blk_t ref_decode(input int p0, input blk_mode_e last);
    exp_blk_t e;
    int       p;
    e = '0;
    p = p0;
    if (stream[p])
    begin
      e.mode = last;
      p += 1;
    end
    else if (stream[p+1] && stream[p+2])
    begin
      e.mode = stream[p+3] ? MPPF : BPSKIP;
      p += 4;
    end
    else
    begin
      e.mode = blk_mode_e'({1'b0, stream[p+1], stream[p+2]});
      p += 3;
    end
    p += stream[p] ? 3 : 1;
    if (e.mode == MPP)
    begin
      e.step = {stream[p+1], stream[p+2], stream[p+3]};
      p += 4;
    end
    else if (e.mode == BP)
    begin
      for (int i = 0; i < NUM_SUB; i++)
        e.use2x2[i] = stream[p+i];
      p += 4 + (stream[p] ? 5 : 10);
    end
    e.len = p - p0;
    return e;
  endfunction

  task automatic finish_run(input logic timed_out);
    if (timed_out)
      $display("timeout after %0d cycles, only %0d of %0d blocks decoded",
               cycle_cnt, blk_cnt, NUM_BLK);
    $display("%0d errors in %0d blocks", err_cnt, blk_cnt);
    if (err_cnt == 0 && !timed_out)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  endtask

  initial
  begin : stimulus
    start_dec = 1'b0;
    codec_data = '0;
    word_idx = 0;
    void'($urandom(25));
    build_stream();
    wait (rstn);
    repeat (2) @(posedge clk);
    #5;
    start_dec = 1'b1;
    codec_data = words[0];
    forever
    begin
      @(posedge clk);
      #5;
      // source advances only past an edge with rd_en high
      if (took_word)
        word_idx++;
      codec_data = (word_idx < MAX_WORDS) ? words[word_idx] : '0;
    end
  end

  initial
  begin : compare
    exp_blk_t                  e;
    logic                      vld;
    logic                      exp_rd;
    int                        after;
    logic [NUM_SUB+STEP_W+5:0] exp_out;
    logic [NUM_SUB+STEP_W+5:0] got_out;
    took_word = 1'b0;
    err_cnt = 0;
    blk_cnt = 0;
    while (blk_cnt < NUM_BLK)
    begin
      @(negedge clk);
      if (!rstn)
      begin
        model_full = 0;
        started = 1'b0;
        pos = 0;
        prev = XFM;
      end
      vld = started && (model_full != 0);
      e = vld ? ref_decode(pos, prev) : '0;
      after = model_full - e.len;
      exp_rd = start_dec && (after < WORD_W);
      exp_out = '0;
      if (vld)
        exp_out = {1'b1, e.mode == XFM, e.mode == BP, e.mode == MPP,
                   e.mode == MPPF, e.mode == BPSKIP, e.use2x2, e.step};
      got_out = {blk_vld, mode_xfm, mode_bp, mode_mpp, mode_mppf, mode_bpskip,
                 use2x2, mpp_step_size};
      if (codec_data_rd_en !== exp_rd)
      begin
        err_cnt++;
        $display("ERR %0t: rd_en %b, expected %b", $time, codec_data_rd_en, exp_rd);
      end
      if (got_out !== exp_out)
      begin
        err_cnt++;
        $display("ERR %0t: block %0d outputs %b, expected %b",
                 $time, blk_cnt, got_out, exp_out);
      end
      took_word = codec_data_rd_en;
      if (vld)
      begin
        pos += e.len;
        prev = e.mode;
        blk_cnt++;
      end
      model_full = after + (exp_rd ? WORD_W : 0);
      if (exp_rd)
        started = 1'b1;
    end
    // reference walk must land exactly on the end of the stream
    if (pos != nbits)
    begin
      err_cnt++;
      $display("ERR %0t: blocks end at bit %0d, stream has %0d", $time, pos, nbits);
    end
    finish_run(1'b0);
  end

  initial
  begin : timeout
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYC)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    finish_run(1'b1);
  end

endmodule

//--- files.f
verilog/bitparse_cfg_pkg.sv
verilog/bitparse_mode_pkg.sv
verilog/bit_window_if.sv
verilog/parse_ctrl_fsm.sv
verilog/fullness_cnt.sv
verilog/funnel_shifter.sv
verilog/mode_header_dec.sv
verilog/block_payload_dec.sv
verilog/bitparse_top.sv
test/bitparse_chk.sv
test/tb_clk_gen.sv
test/bitparse_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the bitparse testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
fail_msg="Errors found"

verilator --binary --timing --assert --top-module bitparse_tb -f files.f -o sim_bitparse
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_bitparse > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "$fail_msg" "$log"; then
  echo "simulation reported failures"
  exit 1
fi

echo "simulation passed"
exit 0
